// File: cpu_pkg.sv
/* Shared types for the accumulator CPU subsystem.
   Instructions are 32 bits with the opcode in 31:28 and a 28-bit operand below it. */

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  irq_id_t;

    // OBI master to slave
    typedef struct packed {
        logic       req;
        logic       we;
        logic [3:0] be;
        addr_t      addr;
        word_t      wdata;
    } obi_req_t;

    // OBI slave to master
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } obi_resp_t;

    typedef enum logic [3:0] {
        OP_LI    = 4'h0,
        OP_ADDI  = 4'h1,
        OP_LD    = 4'h2,
        OP_ST    = 4'h3,
        OP_BNZ   = 4'h4,
        OP_IMASK = 4'h5,
        OP_WFI   = 4'h6,
        OP_MRET  = 4'h7
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_WAIT,
        EXEC,
        DATA_REQ,
        DATA_WAIT,
        SLEEP,
        HALT
    } core_state_e;

    // Handler for interrupt n starts at TRAP_BASE + 4*n
    localparam addr_t TRAP_BASE = 32'h0000_0100;

endpackage

// File: irq_ctrl.sv
/* Interrupt enable mask and priority resolver, highest index wins.
   NUM_IRQ must not exceed 32. Lines at or above NUM_IRQ are ignored. */

`timescale 1ns/1ns

module irq_ctrl #(
    parameter int unsigned NUM_IRQ = 32
) (
    input  logic             clk_i,
    input  logic             reset_i,

    input  cpu_pkg::word_t   irq_i,

    // Mask write from the core
    input  logic             mask_we_i,
    input  cpu_pkg::word_t   mask_wdata_i,

    output logic             irq_pending_o,
    output cpu_pkg::irq_id_t irq_sel_id_o
);

    cpu_pkg::word_t mask_q;
    cpu_pkg::word_t active;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q <= '0;
        end else if (mask_we_i) begin
            mask_q <= mask_wdata_i;
        end
    end

    assign active = irq_i & mask_q;

    // Later lines overwrite earlier ones, so the top enabled index is kept
    always_comb begin
        irq_pending_o = 1'b0;
        irq_sel_id_o  = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (active[i]) begin
                irq_pending_o = 1'b1;
                irq_sel_id_o  = cpu_pkg::irq_id_t'(i);
            end
        end
    end

endmodule

// File: acc_core.sv
/* Multicycle accumulator core with one OBI transaction outstanding per port.
   Opcodes 8 to 15 execute as no-ops. The core leaves reset through HALT, so the
   first fetch request appears one cycle after reset is seen low. */

`timescale 1ns/1ns

module acc_core #(
    parameter cpu_pkg::addr_t BOOT_ADDR = 32'h0000_0180
) (
    input  logic               clk_i,
    input  logic               reset_i,

    // Instruction fetch
    output cpu_pkg::addr_t     instr_addr_o,
    output logic               instr_req_o,
    input  cpu_pkg::obi_resp_t instr_resp_i,

    // Data access
    output cpu_pkg::obi_req_t  data_req_o,
    input  cpu_pkg::obi_resp_t data_resp_i,

    // Interrupt controller side
    input  logic               irq_pending_i,
    input  cpu_pkg::irq_id_t   irq_sel_id_i,
    output logic               mask_we_o,
    output cpu_pkg::word_t     mask_wdata_o,

    output logic               irq_ack_o,
    output cpu_pkg::irq_id_t   irq_id_o,

    input  logic               debug_req_i,
    output logic               core_sleep_o
);

    cpu_pkg::core_state_e state_q;
    cpu_pkg::core_state_e after_instr;

    cpu_pkg::addr_t pc_q;
    cpu_pkg::addr_t ret_q;
    cpu_pkg::addr_t pc_seq;
    cpu_pkg::addr_t trap_addr;
    cpu_pkg::word_t acc_q;
    cpu_pkg::word_t instr_q;
    cpu_pkg::word_t operand;
    cpu_pkg::word_t imm_sext;
    logic           ie_q;

    cpu_pkg::opcode_e opcode;
    logic             in_exec;
    logic             take_trap;
    logic             fetch_done;
    logic             data_done;

    // Decode of the latched instruction
    assign opcode   = cpu_pkg::opcode_e'(instr_q[31:28]);
    assign operand  = {4'b0000, instr_q[27:0]};
    assign imm_sext = {{4{instr_q[27]}}, instr_q[27:0]};

    assign pc_seq    = pc_q + 32'd4;
    assign trap_addr = cpu_pkg::TRAP_BASE + {25'b0, irq_sel_id_i, 2'b00};

    // Where to go once an instruction is done; debug holds off the next fetch
    assign after_instr = debug_req_i ? cpu_pkg::HALT : cpu_pkg::FETCH_REQ;

    assign in_exec   = (state_q == cpu_pkg::EXEC);
    assign take_trap = in_exec && irq_pending_i && ie_q;

    // Response may arrive together with the grant
    assign fetch_done = instr_resp_i.rvalid &&
                        ((state_q == cpu_pkg::FETCH_WAIT) ||
                         (state_q == cpu_pkg::FETCH_REQ && instr_resp_i.gnt));
    assign data_done  = data_resp_i.rvalid &&
                        ((state_q == cpu_pkg::DATA_WAIT) ||
                         (state_q == cpu_pkg::DATA_REQ && data_resp_i.gnt));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= cpu_pkg::HALT;
            pc_q    <= BOOT_ADDR;
            acc_q   <= '0;
            ret_q   <= '0;
            // Enabled out of reset, individual lines stay masked in irq_ctrl
            ie_q    <= 1'b1;
        end else begin
            case (state_q)
                cpu_pkg::FETCH_REQ: begin
                    if (fetch_done) begin
                        state_q <= cpu_pkg::EXEC;
                    end else if (instr_resp_i.gnt) begin
                        state_q <= cpu_pkg::FETCH_WAIT;
                    end
                end
                cpu_pkg::FETCH_WAIT: begin
                    if (fetch_done) begin
                        state_q <= cpu_pkg::EXEC;
                    end
                end
                cpu_pkg::EXEC: begin
                    if (take_trap) begin
                        // Fetched instruction is dropped and re-run after return
                        ret_q   <= pc_q;
                        ie_q    <= 1'b0;
                        pc_q    <= trap_addr;
                        state_q <= after_instr;
                    end else begin
                        pc_q    <= pc_seq;
                        state_q <= after_instr;
                        case (opcode)
                            cpu_pkg::OP_LI:   acc_q <= imm_sext;
                            cpu_pkg::OP_ADDI: acc_q <= acc_q + imm_sext;
                            cpu_pkg::OP_LD,
                            cpu_pkg::OP_ST:   state_q <= cpu_pkg::DATA_REQ;
                            cpu_pkg::OP_BNZ: begin
                                if (acc_q != '0) begin
                                    pc_q <= operand;
                                end
                            end
                            cpu_pkg::OP_WFI: begin
                                if (!irq_pending_i) begin
                                    state_q <= cpu_pkg::SLEEP;
                                end
                            end
                            cpu_pkg::OP_MRET: begin
                                pc_q <= ret_q;
                                ie_q <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                cpu_pkg::DATA_REQ: begin
                    if (data_done) begin
                        if (opcode == cpu_pkg::OP_LD) begin
                            acc_q <= data_resp_i.rdata;
                        end
                        state_q <= after_instr;
                    end else if (data_resp_i.gnt) begin
                        state_q <= cpu_pkg::DATA_WAIT;
                    end
                end
                cpu_pkg::DATA_WAIT: begin
                    if (data_done) begin
                        if (opcode == cpu_pkg::OP_LD) begin
                            acc_q <= data_resp_i.rdata;
                        end
                        state_q <= after_instr;
                    end
                end
                cpu_pkg::SLEEP: begin
                    // Wake on any enabled line, the trap follows on the next fetch
                    if (irq_pending_i) begin
                        state_q <= after_instr;
                    end
                end
                cpu_pkg::HALT: begin
                    if (!debug_req_i) begin
                        state_q <= cpu_pkg::FETCH_REQ;
                    end
                end
                default: state_q <= cpu_pkg::HALT;
            endcase
        end
    end

    // Instruction word, only written by a fetch response
    always_ff @(posedge clk_i) begin
        if (fetch_done) begin
            instr_q <= instr_resp_i.rdata;
        end
    end

    assign instr_req_o  = (state_q == cpu_pkg::FETCH_REQ);
    assign instr_addr_o = pc_q;

    // instr_q and acc_q do not change while a data request is open
    assign data_req_o.req   = (state_q == cpu_pkg::DATA_REQ);
    assign data_req_o.we    = (opcode == cpu_pkg::OP_ST);
    assign data_req_o.be    = 4'b1111;
    assign data_req_o.addr  = operand;
    assign data_req_o.wdata = acc_q;

    assign mask_we_o    = in_exec && !take_trap && (opcode == cpu_pkg::OP_IMASK);
    assign mask_wdata_o = operand;

    assign irq_ack_o = take_trap;
    assign irq_id_o  = irq_sel_id_i;

    assign core_sleep_o = (state_q == cpu_pkg::SLEEP);

endmodule

// File: cpu_subsystem.sv
/* CPU subsystem with the accumulator core and its interrupt controller.
   Fetch is always enabled; the instruction port never writes.
   debug_req_i only halts fetch at the next instruction boundary. */

`timescale 1ns/1ns

module cpu_subsystem #(
    parameter cpu_pkg::addr_t BOOT_ADDR = 32'h0000_0180,
    parameter int unsigned    NUM_IRQ   = 32
) (
    input  logic               clk_i,
    input  logic               reset_i,

    // Instruction memory
    output cpu_pkg::obi_req_t  core_instr_req_o,
    input  cpu_pkg::obi_resp_t core_instr_resp_i,

    // Data memory
    output cpu_pkg::obi_req_t  core_data_req_o,
    input  cpu_pkg::obi_resp_t core_data_resp_i,

    // Interrupts
    input  cpu_pkg::word_t     irq_i,
    output logic               irq_ack_o,
    output cpu_pkg::irq_id_t   irq_id_o,

    input  logic               debug_req_i,
    output logic               core_sleep_o
);

    cpu_pkg::addr_t   instr_addr;
    logic             instr_req;
    logic             mask_we;
    cpu_pkg::word_t   mask_wdata;
    logic             irq_pending;
    cpu_pkg::irq_id_t irq_sel_id;

    // Read-only fetch port
    assign core_instr_req_o = '{
        req:   instr_req,
        we:    1'b0,
        be:    4'b1111,
        addr:  instr_addr,
        wdata: '0
    };

    acc_core #(
        .BOOT_ADDR(BOOT_ADDR)
    ) core0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_addr_o (instr_addr),
        .instr_req_o  (instr_req),
        .instr_resp_i (core_instr_resp_i),
        .data_req_o   (core_data_req_o),
        .data_resp_i  (core_data_resp_i),
        .irq_pending_i(irq_pending),
        .irq_sel_id_i (irq_sel_id),
        .mask_we_o    (mask_we),
        .mask_wdata_o (mask_wdata),
        .irq_ack_o    (irq_ack_o),
        .irq_id_o     (irq_id_o),
        .debug_req_i  (debug_req_i),
        .core_sleep_o (core_sleep_o)
    );

    irq_ctrl #(
        .NUM_IRQ(NUM_IRQ)
    ) irq0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .irq_i        (irq_i),
        .mask_we_i    (mask_we),
        .mask_wdata_i (mask_wdata),
        .irq_pending_o(irq_pending),
        .irq_sel_id_o (irq_sel_id)
    );

endmodule

// File: tb_obi_mem.sv
/* OBI slave timing model for simulation. Grant and response delays of 0 to 3 cycles
   come from an xorshift generator. Data comes from rdata_i at the address on addr_o. */

`timescale 1ns/1ns

module tb_obi_mem #(
    parameter logic [31:0] SEED = 32'd42
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  cpu_pkg::obi_req_t  req_i,
    output cpu_pkg::obi_resp_t resp_o,
    input  cpu_pkg::word_t     rdata_i,
    output cpu_pkg::addr_t     addr_o
);

    logic [31:0]    rng_q;
    logic [1:0]     gnt_wait_q;
    logic [1:0]     rv_wait_q;
    logic           busy_q;
    cpu_pkg::addr_t addr_q;
    logic           gnt;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign gnt           = req_i.req && !busy_q && (gnt_wait_q == 2'd0);
    assign resp_o.gnt    = gnt;
    // Zero response delay gives rvalid together with the grant
    assign resp_o.rvalid = (gnt || busy_q) && (rv_wait_q == 2'd0);
    assign resp_o.rdata  = rdata_i;
    assign addr_o        = busy_q ? addr_q : req_i.addr;

    always @(posedge clk_i) begin
        if (reset_i) begin
            rng_q      <= SEED;
            gnt_wait_q <= 2'd0;
            rv_wait_q  <= 2'd0;
            busy_q     <= 1'b0;
        end else if (resp_o.rvalid) begin
            // New delays for the next transaction
            busy_q     <= 1'b0;
            gnt_wait_q <= rng_q[1:0];
            rv_wait_q  <= rng_q[3:2];
            rng_q      <= xorshift(rng_q);
        end else if (gnt) begin
            busy_q    <= 1'b1;
            addr_q    <= req_i.addr;
            rv_wait_q <= rv_wait_q - 2'd1;
        end else if (busy_q) begin
            rv_wait_q <= rv_wait_q - 2'd1;
        end else if (req_i.req) begin
            gnt_wait_q <= gnt_wait_q - 2'd1;
        end
    end

endmodule

// File: cpu_subsystem_assertions.sv
/* Bus protocol assertions, bound into cpu_subsystem. */

`timescale 1ns/1ns

module cpu_subsystem_assertions (
    input logic               clk_i,
    input logic               reset_i,
    input cpu_pkg::obi_req_t  instr_req_i,
    input cpu_pkg::obi_resp_t instr_resp_i,
    input cpu_pkg::obi_req_t  data_req_i,
    input cpu_pkg::obi_resp_t data_resp_i,
    input logic               irq_ack_i
);

    // Request fields hold until granted
    instr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_req_i.req && !instr_resp_i.gnt |=> $stable(instr_req_i))
        else $error("instruction request changed before its grant");

    data_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        data_req_i.req && !data_resp_i.gnt |=> $stable(data_req_i))
        else $error("data request changed before its grant");

    ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
        irq_ack_i |=> !irq_ack_i)
        else $error("irq_ack_o high for two cycles");

endmodule

bind cpu_subsystem cpu_subsystem_assertions asrt0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .instr_req_i (core_instr_req_o),
    .instr_resp_i(core_instr_resp_i),
    .data_req_i  (core_data_req_o),
    .data_resp_i (core_data_resp_i),
    .irq_ack_i   (irq_ack_o)
);

// File: tb_cpu_subsystem.sv
/* Testbench for cpu_subsystem with one shared 4 KB memory behind both OBI ports.
   Data checks cover addresses 0x200 to 0x3FF. */

`timescale 1ns/1ns

module tb_cpu_subsystem;

    localparam cpu_pkg::addr_t BOOT  = 32'h0000_0180;
    localparam cpu_pkg::word_t MASK  = 32'h0000_0208;
    localparam cpu_pkg::word_t LINES = 32'h0010_0208;
    localparam int LIMIT = 3000;

    logic               clk_i;
    logic               reset_i;
    logic               debug_req;
    logic               ack;
    logic               sleep;
    logic               prev_req;
    cpu_pkg::word_t     irq;
    cpu_pkg::irq_id_t   ack_id;
    cpu_pkg::irq_id_t   exp_id;
    cpu_pkg::obi_req_t  i_req;
    cpu_pkg::obi_req_t  d_req;
    cpu_pkg::obi_resp_t i_resp;
    cpu_pkg::obi_resp_t d_resp;
    cpu_pkg::addr_t     i_addr;
    cpu_pkg::addr_t     d_addr;
    cpu_pkg::word_t     mem [1024];
    cpu_pkg::word_t     img [1024];
    cpu_pkg::word_t     exp_mem [1024];
    cpu_pkg::addr_t     exp_st_addr [16];
    cpu_pkg::word_t     exp_st_data [16];
    int                 n_exp_st;
    int                 st_idx;
    int                 ack_count;
    int                 st_errors = 0;
    int                 errors = 0;
    int                 t;

    cpu_subsystem #(
        .BOOT_ADDR(BOOT),
        .NUM_IRQ  (32)
    ) dut0 (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .core_instr_req_o (i_req),
        .core_instr_resp_i(i_resp),
        .core_data_req_o  (d_req),
        .core_data_resp_i (d_resp),
        .irq_i            (irq),
        .irq_ack_o        (ack),
        .irq_id_o         (ack_id),
        .debug_req_i      (debug_req),
        .core_sleep_o     (sleep)
    );

    tb_obi_mem #(.SEED(32'd42)) imem0 (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .req_i  (i_req),
        .resp_o (i_resp),
        .rdata_i(mem[i_addr[11:2]]),
        .addr_o (i_addr)
    );

    tb_obi_mem #(.SEED(32'd42)) dmem0 (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .req_i  (d_req),
        .resp_o (d_resp),
        .rdata_i(mem[d_addr[11:2]]),
        .addr_o (d_addr)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Program image is copied in during reset, stores land on grant
    always @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= img[i];
            end
        end else if (d_resp.gnt && d_req.we) begin
            mem[d_req.addr[11:2]] <= d_req.wdata;
        end
    end

    // Store order and acknowledge count
    always @(posedge clk_i) begin
        if (reset_i) begin
            st_idx    <= 0;
            ack_count <= 0;
        end else begin
            if (ack) begin
                ack_count <= ack_count + 1;
            end
            if (d_resp.gnt && d_req.we) begin
                if (st_idx >= n_exp_st) begin
                    $display("Unexpected extra store to address %h", d_req.addr);
                    st_errors <= st_errors + 1;
                end else if (d_req.addr != exp_st_addr[st_idx] ||
                             d_req.wdata != exp_st_data[st_idx]) begin
                    $display("CHECK FAILED core_data_req_o addr %h data %h expected %h %h",
                             d_req.addr, d_req.wdata, exp_st_addr[st_idx], exp_st_data[st_idx]);
                    st_errors <= st_errors + 1;
                end else if (d_req.be != 4'b1111) begin
                    $display("CHECK FAILED core_data_req_o.be got %h expected %h",
                             d_req.be, 4'b1111);
                    st_errors <= st_errors + 1;
                end
                st_idx <= st_idx + 1;
            end
        end
    end

    task automatic check_value(input string name, input cpu_pkg::word_t got,
                               input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic put_instr(input cpu_pkg::addr_t a, input cpu_pkg::opcode_e op,
                             input cpu_pkg::word_t arg);
        img[a[11:2]] = {op, arg[27:0]};
    endtask

    // Search from the top line down
    function automatic cpu_pkg::irq_id_t highest_index(input cpu_pkg::word_t v);
        cpu_pkg::irq_id_t r;
        logic             found;
        r     = '0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (v[i] && !found) begin
                r     = cpu_pkg::irq_id_t'(i);
                found = 1'b1;
            end
        end
        return r;
    endfunction

    // ISA model; a taken branch to itself ends the program
    function automatic void ref_run(input logic irq_on, input cpu_pkg::irq_id_t id);
        cpu_pkg::addr_t pc;
        cpu_pkg::addr_t nxt;
        cpu_pkg::addr_t ret_pc;
        cpu_pkg::word_t arg;
        cpu_pkg::word_t imm;
        cpu_pkg::word_t ins;
        cpu_pkg::word_t acc;
        logic           ie;
        logic           trap_due;
        pc       = BOOT;
        ret_pc   = '0;
        acc      = '0;
        ie       = 1'b1;
        trap_due = 1'b0;
        n_exp_st = 0;
        for (int i = 0; i < 1024; i++) begin
            exp_mem[i] = img[i];
        end
        for (int step = 0; step < 1000; step++) begin
            // Interrupt taken before the instruction after the WFI
            if (trap_due && ie) begin
                ret_pc   = pc;
                pc       = cpu_pkg::TRAP_BASE + 32'd4 * id;
                ie       = 1'b0;
                trap_due = 1'b0;
            end
            ins = exp_mem[pc[11:2]];
            arg = {4'b0000, ins[27:0]};
            imm = {{4{ins[27]}}, ins[27:0]};
            nxt = pc + 32'd4;
            case (cpu_pkg::opcode_e'(ins[31:28]))
                cpu_pkg::OP_LI:   acc = imm;
                cpu_pkg::OP_ADDI: acc = acc + imm;
                cpu_pkg::OP_LD:   acc = exp_mem[arg[11:2]];
                cpu_pkg::OP_ST: begin
                    exp_mem[arg[11:2]]    = acc;
                    exp_st_addr[n_exp_st] = arg;
                    exp_st_data[n_exp_st] = acc;
                    n_exp_st++;
                end
                cpu_pkg::OP_BNZ: begin
                    if (acc != '0 && arg == pc) begin
                        return;
                    end else if (acc != '0) begin
                        nxt = arg;
                    end
                end
                cpu_pkg::OP_WFI:  trap_due = irq_on;
                cpu_pkg::OP_MRET: begin
                    nxt = ret_pc;
                    ie  = 1'b1;
                end
                default: ;
            endcase
            pc = nxt;
        end
    endfunction

    task automatic load_loop_program;
        for (int i = 0; i < 1024; i++) begin
            img[i] = 32'hE000_0000 ^ i;
        end
        img[129] = 32'h0000_0011;
        put_instr(32'h180, cpu_pkg::OP_LI, 32'd5);
        put_instr(32'h184, cpu_pkg::OP_ST, 32'h200);
        put_instr(32'h188, cpu_pkg::OP_LD, 32'h204);
        put_instr(32'h18C, cpu_pkg::OP_ADDI, 32'hFFFF_FFFD);
        put_instr(32'h190, cpu_pkg::OP_ST, 32'h208);
        // Countdown loop storing 3, 2, 1
        put_instr(32'h194, cpu_pkg::OP_LI, 32'd3);
        put_instr(32'h198, cpu_pkg::OP_ST, 32'h20C);
        put_instr(32'h19C, cpu_pkg::OP_ADDI, 32'hFFFF_FFFF);
        put_instr(32'h1A0, cpu_pkg::OP_BNZ, 32'h198);
        put_instr(32'h1A4, cpu_pkg::OP_LI, 32'd1);
        put_instr(32'h1A8, cpu_pkg::OP_ST, 32'h2F0);
        put_instr(32'h1AC, cpu_pkg::OP_BNZ, 32'h1AC);
    endtask

    task automatic load_irq_program;
        for (int i = 0; i < 1024; i++) begin
            img[i] = 32'hE000_0000 ^ i;
        end
        put_instr(32'h180, cpu_pkg::OP_LI, 32'd7);
        put_instr(32'h184, cpu_pkg::OP_ST, 32'h210);
        put_instr(32'h188, cpu_pkg::OP_IMASK, MASK);
        put_instr(32'h18C, cpu_pkg::OP_WFI, 32'd0);
        put_instr(32'h190, cpu_pkg::OP_ADDI, 32'd1);
        put_instr(32'h194, cpu_pkg::OP_ST, 32'h214);
        put_instr(32'h198, cpu_pkg::OP_BNZ, 32'h198);
        // Handler for line 9
        put_instr(32'h124, cpu_pkg::OP_LI, 32'h5A);
        put_instr(32'h128, cpu_pkg::OP_ST, 32'h300);
        put_instr(32'h12C, cpu_pkg::OP_MRET, 32'd0);
    endtask

    task automatic check_idle;
        if (i_req.req || d_req.req || ack || sleep) begin
            $display("Outputs not idle around reset");
            errors++;
        end
    endtask

    task automatic apply_reset;
        reset_i <= 1'b1;
        @(posedge clk_i);
        @(posedge clk_i);
        check_idle();
        reset_i <= 1'b0;
        @(posedge clk_i);
        check_idle();
    endtask

    task automatic wait_stores(input int n);
        t = 0;
        while (st_idx < n && t < LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (st_idx < n) begin
            $display("Timeout while waiting for store number %0d", n);
            errors++;
        end
        @(posedge clk_i);
    endtask

    task automatic compare_memory;
        for (int i = 128; i < 256; i++) begin
            check_value($sformatf("mem[%h]", i * 4), mem[i], exp_mem[i]);
        end
    endtask

    task automatic wait_fetch;
        t = 0;
        while (!i_req.req && t < LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (!i_req.req) begin
            $display("Timeout while waiting for an instruction request");
            errors++;
        end
    endtask

    initial begin
        reset_i   = 1'b1;
        debug_req = 1'b0;
        irq       = '0;

        // Reset state, arithmetic, loads, stores and loop
        load_loop_program();
        ref_run(1'b0, '0);
        apply_reset();
        wait_fetch();
        check_value("core_instr_req_o.addr", i_req.addr, BOOT);
        // Fetch port is read-only with all byte lanes
        check_value("core_instr_req_o.we", {31'b0, i_req.we}, 32'd0);
        check_value("core_instr_req_o.be", {28'b0, i_req.be}, 32'h0000_000F);
        check_value("core_instr_req_o.wdata", i_req.wdata, 32'd0);
        wait_stores(n_exp_st);
        compare_memory();

        // Sleep, interrupt selection and return
        load_irq_program();
        exp_id = highest_index(MASK & LINES);
        ref_run(1'b1, exp_id);
        apply_reset();
        t = 0;
        while (!sleep && t < LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (!sleep) begin
            $display("Timeout while waiting for core_sleep_o");
            errors++;
        end
        irq <= 32'd1 << 20;
        repeat (20) begin
            @(posedge clk_i);
            if (!sleep) begin
                $display("core_sleep_o fell while only a masked line was asserted");
                errors++;
            end
        end
        irq <= LINES;
        t = 0;
        while (!ack && t < LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (!ack) begin
            $display("Timeout while waiting for irq_ack_o");
            errors++;
        end
        check_value("irq_id_o", {27'b0, ack_id}, {27'b0, exp_id});
        check_value("core_sleep_o", {31'b0, sleep}, 32'd0);
        irq <= '0;
        @(posedge clk_i);
        wait_fetch();
        check_value("core_instr_req_o.addr", i_req.addr,
                    cpu_pkg::TRAP_BASE + 32'd4 * exp_id);
        wait_stores(n_exp_st);
        compare_memory();
        check_value("irq_ack_o pulse count", ack_count, 32'd1);

        // Debug halt in the middle of the loop program
        load_loop_program();
        ref_run(1'b0, '0);
        apply_reset();
        wait_stores(2);
        debug_req <= 1'b1;
        @(posedge clk_i);
        prev_req = i_req.req;
        repeat (40) begin
            @(posedge clk_i);
            if (i_req.req && !prev_req) begin
                $display("New instruction request started during debug halt");
                errors++;
            end
            prev_req = i_req.req;
        end
        debug_req <= 1'b0;
        wait_stores(n_exp_st);
        compare_memory();

        $display("Error counts: %0d checks, %0d store compares", errors, st_errors);
        if (errors + st_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim.f
cpu_pkg.sv
irq_ctrl.sv
acc_core.sv
cpu_subsystem.sv
tb_obi_mem.sv
cpu_subsystem_assertions.sv
tb_cpu_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpu_subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_subsystem \
    -f sim.f -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
